//--- rtl/cop_addr_decoder.sv
module cop_addr_decoder (
    input  cop_bus_pkg::bus_addr_u             adr,
    input  logic                               we,
    input  logic                               acc,      // cyc & stb
    output logic                               ram_cs,
    output logic [cop_bus_pkg::rd_cs_w-1:0]    rd_cs,
    output logic [cop_bus_pkg::wr_cs_w-1:0]    wr_cs,
    output logic [cop_bus_pkg::vid_sel_w-1:0]  vid_sel
);

    logic low_page;

    assign low_page = adr.vid_view.page == cop_bus_pkg::page_low;

    always_comb begin
        ram_cs  = 1'b0;
        rd_cs   = '0;
        wr_cs   = '0;
        vid_sel = '0;
        if (acc && low_page) begin
            // display chips at 0x24xxxx
            if (adr.vid_view.region == cop_bus_pkg::region_vid &&
                adr.vid_view.sub == cop_bus_pkg::sub_dsp) begin
                if (adr.vid_view.window < cop_bus_pkg::win_third) begin
                    vid_sel[adr.vid_view.window] = 1'b1;     // first two chips, 0x2000 apart
                end else if (adr.vid_view.window == cop_bus_pkg::win_third &&
                             adr.vid_view.chip_reg != 2'd3) begin
                    // third chip packs its windows 0x800 apart
                    vid_sel[int'(cop_bus_pkg::win_third) + int'(adr.vid_view.chip_reg)] = 1'b1;
                end
            end
            if (adr.io_view.region == cop_bus_pkg::region_io) begin
                case (adr.io_view.bank)
                    cop_bus_pkg::bank_io: begin
                        if (!we && !adr.io_view.wr_half) begin   // reads below 0x30c010
                            case (adr.io_view.reg_idx)
                                cop_bus_pkg::reg_cab0,
                                cop_bus_pkg::reg_cab1,
                                cop_bus_pkg::reg_dsw,
                                cop_bus_pkg::reg_sec,
                                cop_bus_pkg::reg_status: rd_cs[adr.io_view.reg_idx] = 1'b1;
                                default: ;                       // idx 3 not fitted
                            endcase
                        end
                        if (we && adr.io_view.wr_half) begin     // writes from 0x30c010
                            case (adr.io_view.reg_idx)
                                cop_bus_pkg::reg_prisel: wr_cs[0] = 1'b1;
                                cop_bus_pkg::reg_sndcmd: wr_cs[1] = 1'b1;
                                cop_bus_pkg::reg_vclr:   wr_cs[2] = 1'b1;
                                default: ;
                            endcase
                        end
                    end
                    cop_bus_pkg::bank_ram: ram_cs = 1'b1;        // mirrors every 4K bytes
                    default: ;
                endcase
            end
        end
    end

    // ram, io and video selects share one bus slot
    always_comb begin
        assert ($onehot0({ram_cs, rd_cs, wr_cs, vid_sel}))
            else $error("cop_addr_decoder: more than one select active");
    end

endmodule

//--- rtl/cop_bus_pkg.sv
package cop_bus_pkg;

    localparam int addr_w    = 23;            // word address, adr[23:1]
    localparam int data_w    = 16;
    localparam int ram_aw    = 11;            // 2K words, mirrors across 0x318000
    localparam int snd_depth = 4;
    localparam int snd_aw    = $clog2(snd_depth);
    localparam int snd_w     = 8;             // sound command byte
    localparam int vid_sel_w = 9;             // 3 tile chips x mode/scroll/map
    localparam int rd_cs_w   = 6;             // one bit per read reg_idx
    localparam int wr_cs_w   = 3;             // prisel, sndcmd, vclr

    localparam logic [1:0] page_low   = 2'd0; // adr[23:22], upper pages unmapped
    localparam logic [1:0] region_vid = 2'd2; // 0x2xxxxx
    localparam logic [1:0] region_io  = 2'd3; // 0x3xxxxx ram/io
    localparam logic [1:0] sub_dsp    = 2'd1; // 0x24xxxx display chips
    localparam logic [2:0] win_third  = 3'd6; // 0x24c000 third chip, split by chip_reg
    localparam logic [2:0] bank_io    = 3'd3; // 0x30c000
    localparam logic [2:0] bank_ram   = 3'd6; // 0x318000

    // read side, reg_idx = adr[3:1] with adr[4] low
    localparam logic [2:0] reg_cab0   = 3'd0; // 0x30c000
    localparam logic [2:0] reg_cab1   = 3'd1; // 0x30c002
    localparam logic [2:0] reg_dsw    = 3'd2; // 0x30c004
    localparam logic [2:0] reg_sec    = 3'd4; // 0x30c008 service/coin/vblank
    localparam logic [2:0] reg_status = 3'd5; // 0x30c00a fifo level + ovf

    // write side, reg_idx = adr[3:1] with adr[4] high
    localparam logic [2:0] reg_prisel = 3'd0; // 0x30c010
    localparam logic [2:0] reg_sndcmd = 3'd2; // 0x30c014
    localparam logic [2:0] reg_vclr   = 3'd4; // 0x30c018

    typedef struct packed {
        logic [1:0] page;      // adr[23:22]
        logic [1:0] region;    // adr[21:20]
        logic [1:0] sub;       // adr[19:18]
        logic [1:0] dsp_gap;   // adr[17:16]
        logic [2:0] window;    // adr[15:13]
        logic [1:0] chip_reg;  // adr[12:11]
        logic [9:0] low;       // adr[10:1]
    } vid_view_t;

    typedef struct packed {
        logic [1:0] page;      // adr[23:22]
        logic [1:0] region;    // adr[21:20]
        logic [2:0] gap;       // adr[19:17]
        logic [2:0] bank;      // adr[16:14]
        logic [8:0] rest;      // adr[13:5]
        logic       wr_half;   // adr[4]
        logic [2:0] reg_idx;   // adr[3:1]
    } io_view_t;

    typedef union packed {
        vid_view_t vid_view;
        io_view_t  io_view;
    } bus_addr_u;

endpackage

//--- rtl/cop_io_regs.sv
module cop_io_regs (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [cop_bus_pkg::rd_cs_w-1:0]  rd_cs,
    input  logic [cop_bus_pkg::wr_cs_w-1:0]  wr_cs,
    input  logic                             wr_stb,     // first cycle of an access
    input  logic [cop_bus_pkg::data_w-1:0]   dat_w,
    input  logic [cop_bus_pkg::data_w-1:0]   cab_in0,
    input  logic [cop_bus_pkg::data_w-1:0]   cab_in1,
    input  logic [cop_bus_pkg::data_w-1:0]   dsw,
    input  logic                             service,
    input  logic [1:0]                       coin,
    input  logic                             vblank,     // one cycle pulse
    input  logic [cop_bus_pkg::snd_aw:0]     snd_level,
    input  logic                             snd_ovf,
    output logic [cop_bus_pkg::data_w-1:0]   rd_data,
    output logic [3:0]                       prisel,
    output logic                             irq,
    output logic                             snd_push,
    output logic [cop_bus_pkg::snd_w-1:0]    snd_data,
    output logic                             ovf_clr
);

    logic [cop_bus_pkg::data_w-1:0] rd_mux;

    always_comb begin
        rd_mux = '0;
        if (rd_cs[cop_bus_pkg::reg_cab0]) rd_mux = cab_in0;
        if (rd_cs[cop_bus_pkg::reg_cab1]) rd_mux = cab_in1;
        if (rd_cs[cop_bus_pkg::reg_dsw])  rd_mux = dsw;
        if (rd_cs[cop_bus_pkg::reg_sec])  rd_mux = {10'd0, service, coin, 2'd0, irq}; // bits 5:3 as on pcb
        if (rd_cs[cop_bus_pkg::reg_status]) rd_mux = {12'd0, snd_ovf, snd_level};
    end

    assign ovf_clr = wr_stb && rd_cs[cop_bus_pkg::reg_status]; // flag is read then cleared

    always_ff @(posedge clk) begin
        if (wr_stb) begin
            rd_data <= rd_mux;                  // held through the ack cycle
        end
        if (wr_stb && wr_cs[1]) begin
            snd_data <= dat_w[cop_bus_pkg::snd_w-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prisel   <= 4'd0;
            irq      <= 1'b0;
            snd_push <= 1'b0;
        end else begin
            snd_push <= wr_stb && wr_cs[1];     // one push per sound write
            if (wr_stb && wr_cs[0]) begin
                prisel <= dat_w[3:0];
            end
            if (vblank) begin
                irq <= 1'b1;                    // set beats clear
            end else if (wr_stb && wr_cs[2]) begin
                irq <= 1'b0;
            end
        end
    end

    // push lands in the ack cycle, where no new access can strobe
    assert property (@(posedge clk) disable iff (!arst_n)
        snd_push |-> !wr_stb)
        else $error("cop_io_regs: sound push overlaps a new access strobe");

endmodule

//--- rtl/cop_main_bus.sv
module cop_main_bus (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [cop_bus_pkg::addr_w:1]        adr,
    input  logic [cop_bus_pkg::data_w-1:0]      dat_w,
    input  logic [1:0]                          sel,
    output logic [cop_bus_pkg::data_w-1:0]      dat_r,
    output logic                                ack,
    input  logic [cop_bus_pkg::data_w-1:0]      cab_in0,
    input  logic [cop_bus_pkg::data_w-1:0]      cab_in1,
    input  logic [cop_bus_pkg::data_w-1:0]      dsw,
    input  logic                                service,
    input  logic [1:0]                          coin,
    input  logic                                vblank,
    output logic                                irq,
    output logic [3:0]                          prisel,
    output logic [cop_bus_pkg::vid_sel_w-1:0]   vid_sel,
    output logic [cop_bus_pkg::snd_w-1:0]       snd_cmd,
    output logic                                snd_valid,
    input  logic                                snd_pop
);

    logic                             acc;
    logic                             first;       // first cycle of a bus access
    logic                             ram_cs;
    logic [cop_bus_pkg::rd_cs_w-1:0]  rd_cs;
    logic [cop_bus_pkg::wr_cs_w-1:0]  wr_cs;
    logic [cop_bus_pkg::data_w-1:0]   ram_dat;
    logic [cop_bus_pkg::data_w-1:0]   io_dat;
    logic                             ram_q;       // read source taken at first cycle
    logic                             io_q;
    logic                             snd_push;
    logic [cop_bus_pkg::snd_w-1:0]    snd_data;
    logic [cop_bus_pkg::snd_aw:0]     snd_level;
    logic                             snd_ovf;
    logic                             ovf_clr;

    assign acc   = cyc && stb;
    assign first = acc && !ack;                    // no ack while one is out

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack   <= 1'b0;
            ram_q <= 1'b0;
            io_q  <= 1'b0;
        end else begin
            ack <= first;                          // single cycle, one clock after strobe
            if (first) begin
                ram_q <= ram_cs && !we;
                io_q  <= |rd_cs;
            end
        end
    end

    // video and unmapped slots read 0
    always_comb begin
        if (ram_q)     dat_r = ram_dat;
        else if (io_q) dat_r = io_dat;
        else           dat_r = '0;
    end

    cop_addr_decoder u_decoder (
        .adr     (adr),
        .we      (we),
        .acc     (acc),
        .ram_cs  (ram_cs),
        .rd_cs   (rd_cs),
        .wr_cs   (wr_cs),
        .vid_sel (vid_sel)
    );

    cop_work_ram u_work_ram (
        .clk    (clk),
        .ram_cs (ram_cs && first),
        .we     (we),
        .sel    (sel),
        .addr   (adr[cop_bus_pkg::ram_aw:1]),      // aliases inside the window
        .dat_w  (dat_w),
        .dat_r  (ram_dat)
    );

    cop_io_regs u_io_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_cs     (rd_cs),
        .wr_cs     (wr_cs),
        .wr_stb    (first),
        .dat_w     (dat_w),
        .cab_in0   (cab_in0),
        .cab_in1   (cab_in1),
        .dsw       (dsw),
        .service   (service),
        .coin      (coin),
        .vblank    (vblank),
        .snd_level (snd_level),
        .snd_ovf   (snd_ovf),
        .rd_data   (io_dat),
        .prisel    (prisel),
        .irq       (irq),
        .snd_push  (snd_push),
        .snd_data  (snd_data),
        .ovf_clr   (ovf_clr)
    );

    cop_snd_fifo u_snd_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (snd_push),
        .push_data (snd_data),
        .pop       (snd_pop),
        .head      (snd_cmd),
        .valid     (snd_valid),
        .level     (snd_level),
        .ovf       (snd_ovf),
        .ovf_clr   (ovf_clr)
    );

endmodule

//--- rtl/cop_snd_fifo.sv
module cop_snd_fifo (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             push,
    input  logic [cop_bus_pkg::snd_w-1:0]    push_data,
    input  logic                             pop,
    output logic [cop_bus_pkg::snd_w-1:0]    head,
    output logic                             valid,
    output logic [cop_bus_pkg::snd_aw:0]     level,
    output logic                             ovf,       // sticky
    input  logic                             ovf_clr
);

    logic [cop_bus_pkg::snd_w-1:0]  mem [cop_bus_pkg::snd_depth];
    logic [cop_bus_pkg::snd_aw-1:0] wr_ptr;
    logic [cop_bus_pkg::snd_aw-1:0] rd_ptr;
    logic                           full;
    logic                           do_push;
    logic                           do_pop;

    assign full    = int'(level) == cop_bus_pkg::snd_depth;
    assign valid   = level != '0;
    assign head    = mem[rd_ptr];
    assign do_push = push && !full;             // full fifo drops the command
    assign do_pop  = pop && valid;              // pop on empty ignored

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: ;
            endcase
            if (push && full) begin
                ovf <= 1'b1;
            end else if (ovf_clr) begin
                ovf <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        int'(level) <= cop_bus_pkg::snd_depth)
        else $error("cop_snd_fifo: level above depth");

endmodule

//--- rtl/cop_work_ram.sv
module cop_work_ram (
    input  logic                             clk,
    input  logic                             ram_cs,   // first cycle of access only
    input  logic                             we,
    input  logic [1:0]                       sel,      // [1] upper byte, [0] lower byte
    input  logic [cop_bus_pkg::ram_aw-1:0]   addr,
    input  logic [cop_bus_pkg::data_w-1:0]   dat_w,
    output logic [cop_bus_pkg::data_w-1:0]   dat_r
);

    localparam int words = 2 ** cop_bus_pkg::ram_aw;

    logic [cop_bus_pkg::data_w-1:0] mem [words];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (ram_cs && we) begin
            if (sel[0]) begin
                mem[addr][7:0] <= dat_w[7:0];
            end
            if (sel[1]) begin
                mem[addr][15:8] <= dat_w[15:8];
            end
        end
    end

    // registered read, data lands in the ack cycle
    always_ff @(posedge clk) begin
        if (ram_cs && !we) begin
            dat_r <= mem[addr];
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the main bus testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_cop_main_bus -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1

//--- tests/cop_bus_checker.sv
module cop_bus_checker (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [23:1] adr,
    input  logic [15:0] dat_w,
    input  logic [1:0]  sel,
    input  logic [15:0] dat_r,
    input  logic        ack,
    input  logic [15:0] cab_in0,
    input  logic [15:0] cab_in1,
    input  logic [15:0] dsw,
    input  logic        service,
    input  logic [1:0]  coin,
    input  logic        vblank,
    input  logic        irq,
    input  logic [3:0]  prisel,
    input  logic [8:0]  vid_sel,
    input  logic [7:0]  snd_cmd,
    input  logic        snd_valid,
    input  logic        snd_pop,
    output int          checks,
    output int          errors
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] ram_m [2048];    // work ram model
    logic [7:0]  fifo_m [$];      // sound commands in order
    logic        ack_m;
    logic        irq_m;
    logic        ovf_m;
    logic        push_m;          // push lands one cycle after the write ack edge
    logic [7:0]  sdata_m;
    logic [3:0]  prisel_m;
    logic [15:0] rdata_m;
    int          n_checks = 0;
    int          n_errors = 0;

    assign checks = n_checks;
    assign errors = n_errors;

    // target: 0 unmapped, 1 ram, 16+idx read reg, 32+idx write reg, 64+bit video
    function automatic int target_of(logic [23:0] a, logic wr);
        if (a[23:18] == 6'h09) begin                         // 0x24xxxx display chips
            if (a[15:13] < 3'd6) return 64 + int'(a[15:13]);
            if (a[15:13] == 3'd6 && a[12:11] != 2'd3) return 70 + int'(a[12:11]);
            return 0;
        end
        if (a[23:14] == 10'h0c6) return 1;                   // 0x318000 to 0x31bfff
        if (!wr && a[23:4] == 20'h30c00 && a[3:1] != 3'd3 && a[3:1] <= 3'd5)
            return 16 + int'(a[3:1]);
        if (wr && a[23:4] == 20'h30c01 && !a[1] && a[3:1] <= 3'd4)
            return 32 + int'(a[3:1]);
        return 0;
    endfunction

    function automatic logic [15:0] read_value(int t, logic [23:0] a);
        case (t)
            1:       return ram_m[a[11:1]];
            16:      return cab_in0;
            17:      return cab_in1;
            18:      return dsw;
            20:      return {10'd0, service, coin, 2'd0, irq_m};   // irq flag in bit 0
            21:      return {12'd0, ovf_m, 3'(fifo_m.size())};
            default: return 16'h0000;                            // video and holes
        endcase
    endfunction

    task automatic compare_value(string name, logic [15:0] got, logic [15:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    always @(negedge clk) begin
        logic [23:0] a;
        logic [8:0]  vid_exp;
        logic        first;
        logic        full;
        int          t;
        a = {adr, 1'b0};
        t = target_of(a, we);
        vid_exp = (cyc && stb && t >= 64) ? 9'(1 << (t - 64)) : 9'd0;
        if (!arst_n) begin
            ack_m    = 1'b0;
            irq_m    = 1'b0;
            ovf_m    = 1'b0;
            push_m   = 1'b0;
            prisel_m = 4'd0;
            rdata_m  = 16'h0000;
            fifo_m.delete();
        end else begin
            compare_value("ack", 16'(ack), 16'(ack_m));
            if (ack_m) compare_value("dat_r", dat_r, rdata_m);
            compare_value("irq", 16'(irq), 16'(irq_m));
            compare_value("prisel", 16'(prisel), 16'(prisel_m));
            compare_value("vid_sel", 16'(vid_sel), 16'(vid_exp));
            compare_value("snd_valid", 16'(snd_valid), 16'(fifo_m.size() != 0));
            if (fifo_m.size() != 0) compare_value("snd_cmd", 16'(snd_cmd), 16'(fifo_m[0]));
            first = cyc && stb && !ack_m;                     // strobe while no ack out
            full  = fifo_m.size() == 4;
            if (first) rdata_m = we ? 16'h0000 : read_value(t, a);
            if (push_m && full) ovf_m = 1'b1;                 // dropped command
            else if (first && t == 21) ovf_m = 1'b0;          // status read clears
            if (snd_pop && fifo_m.size() != 0) void'(fifo_m.pop_front());
            if (push_m && !full) fifo_m.push_back(sdata_m);
            push_m = first && t == 34;
            if (push_m) sdata_m = dat_w[7:0];
            if (vblank) irq_m = 1'b1;                         // set wins over clear
            else if (first && t == 36) irq_m = 1'b0;
            if (first && t == 32) prisel_m = dat_w[3:0];
            if (first && t == 1 && we) begin
                if (sel[0]) ram_m[a[11:1]][7:0] = dat_w[7:0];
                if (sel[1]) ram_m[a[11:1]][15:8] = dat_w[15:8];
            end
            ack_m = first;
        end
    end

endmodule

//--- tests/tb_cop_main_bus.sv
module tb_cop_main_bus;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 5000;  // far above the few hundred cycles used

    logic        clk = 1'b0;
    logic        arst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [23:1] adr;
    logic [15:0] dat_w;
    logic [1:0]  sel;
    logic [15:0] dat_r;
    logic        ack;
    logic [15:0] cab_in0;
    logic [15:0] cab_in1;
    logic [15:0] dsw;
    logic        service;
    logic [1:0]  coin;
    logic        vblank;
    logic        irq;
    logic [3:0]  prisel;
    logic [8:0]  vid_sel;
    logic [7:0]  snd_cmd;
    logic        snd_valid;
    logic        snd_pop;
    int          checks;
    int          errors;
    int          cycles = 0;
    logic [31:0] lfsr = 32'h7ebf_0a81;
    logic [15:0] idx [12];               // ram words touched

    always #4 clk = ~clk;

    cop_main_bus cop_main_bus_i (.*);
    cop_bus_checker checker_i (.*);

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    task automatic draw(input int n, output logic [15:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = {v[14:0], lfsr[31]};
        end
    endtask

    function automatic logic [23:0] ram_addr(logic [15:0] w);
        return 24'h318000 | {12'd0, w[10:0], 1'b0};
    endfunction

    task automatic bus_access(input logic wr, input logic [23:0] a,
                              input logic [15:0] d, input logic [1:0] s);
        @(posedge clk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a[23:1];
        dat_w = d;
        sel   = s;
        @(negedge clk);
        while (!ack) @(negedge clk);     // hang caught by the cycle limit
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic bus_write(input logic [23:0] a, input logic [15:0] d, input logic [1:0] s);
        bus_access(1'b1, a, d, s);
    endtask

    task automatic bus_read(input logic [23:0] a);
        bus_access(1'b0, a, 16'h0000, 2'b11);
    endtask

    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", timeout_cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [15:0] v;
        logic [15:0] s;
        arst_n  = 1'b0;
        cyc     = 1'b0;
        stb     = 1'b0;
        we      = 1'b0;
        adr     = '0;
        dat_w   = 16'h0000;
        sel     = 2'b00;
        cab_in0 = 16'h0000;
        cab_in1 = 16'h0000;
        dsw     = 16'h0000;
        service = 1'b0;
        coin    = 2'b00;
        vblank  = 1'b0;
        snd_pop = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // full word first, then a lane merge through another alias
        for (int i = 0; i < 12; i++) begin
            draw(11, idx[i]);
            draw(16, v);
            bus_write(ram_addr(idx[i]), v, 2'b11);
            draw(16, v);
            draw(2, s);
            bus_write(ram_addr(idx[i]) | 24'h001000, v, s[1:0]);
        end
        for (int i = 0; i < 12; i++) begin
            draw(2, s);
            bus_read(ram_addr(idx[i]) | {10'd0, s[1:0], 12'd0});   // random alias
        end
        draw(16, cab_in0);
        draw(16, cab_in1);
        draw(16, dsw);
        service = 1'b1;
        coin    = 2'b10;
        bus_read(24'h30c000);
        bus_read(24'h30c002);
        bus_read(24'h30c004);
        bus_read(24'h30c008);
        draw(16, v);
        bus_write(24'h30c010, v, 2'b11);
        draw(16, v);
        bus_write(24'h30c010, v, 2'b11);
        for (int w = 0; w < 6; w++) begin
            draw(10, v);
            bus_read((24'h240000 + 24'(w) * 24'h2000) | {13'd0, v[9:0], 1'b0});
        end
        for (int c = 0; c < 4; c++) begin                     // c 3 is a hole
            draw(10, v);
            bus_read((24'h24c000 + 24'(c) * 24'h800) | {13'd0, v[9:0], 1'b0});
        end
        bus_read(24'h24e000);
        bus_read(24'h200000);
        bus_read(24'h100000);
        bus_read(24'h30c006);
        bus_read(24'h400000);
        bus_read(24'hf18000);
        bus_write(24'h300000, 16'hffff, 2'b11);
        bus_write(24'h30c000, 16'hffff, 2'b11);              // input reg is read only
        @(posedge clk);
        #1;
        vblank = 1'b1;
        @(posedge clk);
        #1;
        vblank = 1'b0;
        bus_read(24'h30c008);
        bus_write(24'h30c018, 16'h0000, 2'b11);
        for (int i = 0; i < 6; i++) begin                     // last two overflow
            draw(8, v);
            bus_write(24'h30c014, v, 2'b01);
        end
        bus_read(24'h30c00a);
        bus_read(24'h30c00a);
        @(posedge clk);
        #1;
        while (snd_valid) begin
            snd_pop = 1'b1;
            @(posedge clk);
            #1;
        end
        @(posedge clk);                                       // pop on empty
        #1;
        snd_pop = 1'b0;
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/cop_bus_pkg.sv
rtl/cop_addr_decoder.sv
rtl/cop_work_ram.sv
rtl/cop_io_regs.sv
rtl/cop_snd_fifo.sv
rtl/cop_main_bus.sv
tests/cop_bus_checker.sv
tests/tb_cop_main_bus.sv
